// File: list.f
hdl/kd_tree_pkg.sv
hdl/patch_pkg.sv
hdl/internal_node.sv
hdl/internal_node_tree.sv
hdl/tree_ctrl.sv
hdl/leaf_table.sv
hdl/kd_patch_search.sv
test/tb_kd_patch_search.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the KD-tree patch search testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_kd_patch_search

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_kd_patch_search \
  -f list.f \
  -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "Simulation PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail, see $LOG"
  exit 1
fi

// File: test/tb_kd_patch_search.sv
`timescale 1ns/1ps

module tb_kd_patch_search;

  localparam int RESULT_LATENCY = 7;    // Drive edge to match_valid
  localparam int N_DROP      = 6;       // Patches sent before the first load
  localparam int N_RANDOM    = 120;
  localparam int N_BURST     = 64;      // One patch every cycle
  localparam int N_STRAY     = 10;      // Node strobes outside load mode
  localparam int N_AFTER     = 40;
  localparam int DRAIN_LIMIT = 16;
  localparam int READY_LIMIT = 8;
  // Upper bound on stimulus length, random gaps are at most 3 idle cycles
  localparam int STIM_CYCLES = 8 + N_DROP + 2 + 2 * (kd_tree_pkg::NUM_LEAVES + 1)
                             + 2 * (kd_tree_pkg::NUM_NODES + 3 + READY_LIMIT)
                             + 4 * (N_RANDOM + 2 * N_AFTER) + N_BURST + 1
                             + N_STRAY + 3 + 5 * DRAIN_LIMIT;

  logic                     clk;
  logic                     rst_n;
  logic                     load_start;
  logic                     node_valid;
  kd_tree_pkg::node_word_t  node_data;
  logic                     leaf_wen;
  kd_tree_pkg::leaf_index_t leaf_addr;
  patch_pkg::match_id_t     leaf_data;
  logic                     patch_valid;
  patch_pkg::patch_t        patch_data;
  logic                     tree_ready;
  logic                     match_valid;
  kd_tree_pkg::leaf_index_t match_leaf;
  patch_pkg::match_id_t     match_id;
  logic [7:0]               drop_count;

  // Copies of what the host has written
  kd_tree_pkg::node_word_t shadow_node [kd_tree_pkg::NUM_NODES];
  patch_pkg::match_id_t    shadow_leaf [kd_tree_pkg::NUM_LEAVES];

  // Results still in flight, oldest first
  kd_tree_pkg::leaf_index_t exp_leaf_q [$];
  patch_pkg::match_id_t     exp_id_q [$];
  int unsigned              exp_due_q [$];

  logic [15:0] lfsr_state = 16'd63;
  int unsigned cycle = 0;            // Rising edges seen so far
  int          drops_expected = 0;

  kd_patch_search kd_patch_search_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_start  (load_start),
    .node_valid  (node_valid),
    .node_data   (node_data),
    .leaf_wen    (leaf_wen),
    .leaf_addr   (leaf_addr),
    .leaf_data   (leaf_data),
    .patch_valid (patch_valid),
    .patch_data  (patch_data),
    .tree_ready  (tree_ready),
    .match_valid (match_valid),
    .match_leaf  (match_leaf),
    .match_id    (match_id),
    .drop_count  (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Walk the shadow tree, right on component >= threshold, root decision in the MSB
  function automatic kd_tree_pkg::leaf_index_t ref_leaf(input patch_pkg::patch_t p);
    int                       node;
    int                       sel;
    patch_pkg::component_t    comp;
    kd_tree_pkg::leaf_index_t path;
    node = 0;
    path = '0;
    for (int lvl = 0; lvl < kd_tree_pkg::TREE_DEPTH; lvl++) begin
      sel = int'(shadow_node[node].axis);
      if (sel > patch_pkg::NUM_COMPONENTS - 1) sel = patch_pkg::NUM_COMPONENTS - 1;   // Clamp
      comp = p[sel*patch_pkg::COMPONENT_WIDTH +: patch_pkg::COMPONENT_WIDTH];
      if (comp >= shadow_node[node].thresh) begin
        path = {path[kd_tree_pkg::TREE_DEPTH-2:0], 1'b1};
        node = 2 * node + 2;
      end else begin
        path = {path[kd_tree_pkg::TREE_DEPTH-2:0], 1'b0};
        node = 2 * node + 1;
      end
    end
    return path;
  endfunction

  task automatic check_leaf(input kd_tree_pkg::leaf_index_t got,
                            input kd_tree_pkg::leaf_index_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_id(input patch_pkg::match_id_t got,
                          input patch_pkg::match_id_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      patch_valid <= 1'b0;
    end
  endtask

  // Drive one patch, queue its result if the tree should take it
  task automatic send_patch(input patch_pkg::patch_t p, input logic accept);
    kd_tree_pkg::leaf_index_t leaf;
    @(posedge clk);
    patch_valid <= 1'b1;
    patch_data  <= p;
    if (accept) begin
      leaf = ref_leaf(p);
      exp_leaf_q.push_back(leaf);
      exp_id_q.push_back(shadow_leaf[leaf]);
      exp_due_q.push_back(cycle + 1 + RESULT_LATENCY);   // Counter lags this edge by one
    end else begin
      drops_expected++;
    end
  endtask

  task automatic run_random(input int count);
    logic [63:0] r;
    logic [63:0] gap;
    for (int i = 0; i < count; i++) begin
      random_bits(patch_pkg::PATCH_WIDTH, r);
      send_patch(patch_pkg::patch_t'(r[patch_pkg::PATCH_WIDTH-1:0]), 1'b1);
      random_bits(2, gap);
      idle_cycles(int'(gap[1:0]));   // Zero gap gives back-to-back patches
    end
    idle_cycles(1);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_due_q.size() > 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_due_q.size() > 0) begin
      $display("Pipeline did not drain, %0d results never arrived", exp_due_q.size());
      stop_on_error();
    end
  endtask

  task automatic write_leaf_table();
    logic [63:0] r;
    for (int i = 0; i < kd_tree_pkg::NUM_LEAVES; i++) begin
      random_bits(patch_pkg::MATCH_ID_WIDTH, r);
      @(posedge clk);
      leaf_wen  <= 1'b1;
      leaf_addr <= kd_tree_pkg::leaf_index_t'(i);
      leaf_data <= patch_pkg::match_id_t'(r[patch_pkg::MATCH_ID_WIDTH-1:0]);
      shadow_leaf[i] = patch_pkg::match_id_t'(r[patch_pkg::MATCH_ID_WIDTH-1:0]);
    end
    @(posedge clk);
    leaf_wen <= 1'b0;
  endtask

  // Start pulse, then all nodes breadth-first, ready stays low throughout
  task automatic load_tree();
    logic [63:0] r;
    int          waited;
    @(posedge clk);
    load_start <= 1'b1;
    for (int n = 0; n < kd_tree_pkg::NUM_NODES; n++) begin
      random_bits(kd_tree_pkg::NODE_WIDTH, r);
      @(posedge clk);
      load_start <= 1'b0;
      node_valid <= 1'b1;
      node_data  <= kd_tree_pkg::node_word_t'(r[kd_tree_pkg::NODE_WIDTH-1:0]);
      shadow_node[n] = kd_tree_pkg::node_word_t'(r[kd_tree_pkg::NODE_WIDTH-1:0]);
      @(negedge clk);
      check_flag(tree_ready, 1'b0, "tree_ready during load");
    end
    @(posedge clk);
    node_valid <= 1'b0;
    @(negedge clk);
    check_flag(tree_ready, 1'b0, "tree_ready as the last node lands");   // Load mode still set
    waited = 0;
    while (!tree_ready && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!tree_ready) begin
      $display("tree_ready never rose after all %0d node writes", kd_tree_pkg::NUM_NODES);
      stop_on_error();
    end
    check_count(8'(waited), 8'd1, "cycles from full tree to ready");
  endtask

  task automatic stray_node_writes(input int count);
    logic [63:0] r;
    for (int i = 0; i < count; i++) begin
      random_bits(kd_tree_pkg::NODE_WIDTH, r);
      @(posedge clk);
      node_valid <= 1'b1;
      node_data  <= kd_tree_pkg::node_word_t'(r[kd_tree_pkg::NODE_WIDTH-1:0]);
    end
    @(posedge clk);
    node_valid <= 1'b0;
    @(negedge clk);
    check_flag(tree_ready, 1'b1, "tree_ready after stray node writes");
  endtask

  // Results are sampled away from the driving edge
  always @(negedge clk) begin : compare_results
    kd_tree_pkg::leaf_index_t exp_leaf;
    patch_pkg::match_id_t     exp_id;
    int unsigned              exp_due;
    if (rst_n && match_valid) begin
      if (exp_due_q.size() == 0) begin
        $display("match_valid at %0t ns with no accepted patch in flight", $time);
        stop_on_error();
      end else begin
        exp_leaf = exp_leaf_q.pop_front();
        exp_id   = exp_id_q.pop_front();
        exp_due  = exp_due_q.pop_front();
        if (exp_due != cycle) begin
          $display("[FAIL] %0t ns: result at cycle %0d, expected at cycle %0d",
                   $time, cycle, exp_due);
          stop_on_error();
        end
        check_leaf(match_leaf, exp_leaf, "match_leaf");
        check_id(match_id, exp_id, "match_id");
      end
    end
    if (rst_n && exp_due_q.size() > 0 && exp_due_q[0] < cycle) begin
      $display("Result due at cycle %0d never came", exp_due_q[0]);   // Lost patch
      stop_on_error();
    end
  end

  initial begin : watchdog
    repeat (STIM_CYCLES + 200) @(posedge clk);
    $display("Watchdog expired after %0d cycles", STIM_CYCLES + 200);
    stop_on_error();
  end

  initial begin : stimulus
    logic [63:0] r;
    rst_n       <= 1'b0;
    load_start  <= 1'b0;
    node_valid  <= 1'b0;
    node_data   <= '0;
    leaf_wen    <= 1'b0;
    leaf_addr   <= '0;
    leaf_data   <= '0;
    patch_valid <= 1'b0;
    patch_data  <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag(tree_ready, 1'b0, "tree_ready after reset");
    check_count(drop_count, 8'd0, "drop_count after reset");

    // Nothing loaded yet, every patch is refused
    for (int i = 0; i < N_DROP; i++) begin
      random_bits(patch_pkg::PATCH_WIDTH, r);
      send_patch(patch_pkg::patch_t'(r[patch_pkg::PATCH_WIDTH-1:0]), 1'b0);
    end
    idle_cycles(1);
    @(negedge clk);
    check_count(drop_count, 8'(drops_expected), "drop_count before load");

    write_leaf_table();
    load_tree();

    run_random(N_RANDOM);
    wait_drained();

    // Full-rate run, one result per cycle in order
    for (int i = 0; i < N_BURST; i++) begin
      random_bits(patch_pkg::PATCH_WIDTH, r);
      send_patch(patch_pkg::patch_t'(r[patch_pkg::PATCH_WIDTH-1:0]), 1'b1);
    end
    idle_cycles(1);
    wait_drained();

    // Old tree must survive writes outside load mode
    stray_node_writes(N_STRAY);
    run_random(N_AFTER);
    wait_drained();

    // New ids and a fresh tree
    write_leaf_table();
    load_tree();
    run_random(N_AFTER);
    wait_drained();

    @(negedge clk);
    check_count(drop_count, 8'(drops_expected), "drop_count at end");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: hdl/kd_patch_search.sv
`timescale 1ns/1ps

module kd_patch_search (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_start,
  input  logic                     node_valid,
  input  kd_tree_pkg::node_word_t  node_data,
  input  logic                     leaf_wen,
  input  kd_tree_pkg::leaf_index_t leaf_addr,
  input  patch_pkg::match_id_t     leaf_data,
  input  logic                     patch_valid,
  input  patch_pkg::patch_t        patch_data,
  output logic                     tree_ready,
  output logic                     match_valid,
  output kd_tree_pkg::leaf_index_t match_leaf,
  output patch_pkg::match_id_t     match_id,
  output logic [7:0]               drop_count
);

  logic                     load_enable;   // Node writes allowed
  logic                     tree_full;
  logic                     patch_en;      // Patch admitted to the tree
  logic                     receiver_en;   // Leaf index valid, 6 cycles on
  kd_tree_pkg::leaf_index_t leaf_index;

  // Load mode and patch gating
  tree_ctrl tree_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_start  (load_start),
    .tree_full   (tree_full),
    .patch_valid (patch_valid),
    .load_enable (load_enable),
    .tree_ready  (tree_ready),
    .patch_en    (patch_en),
    .drop_count  (drop_count)
  );

  // Six-level split pipeline
  internal_node_tree internal_node_tree_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fsm_enable    (load_enable),
    .sender_enable (node_valid),
    .load_restart  (load_start),   // Same pulse rewinds the node address
    .patch_en      (patch_en),
    .sender_data   (node_data),
    .patch_in      (patch_data),
    .leaf_index    (leaf_index),
    .receiver_en   (receiver_en),
    .tree_full     (tree_full)
  );

  // Leaf to id lookup, one more cycle
  leaf_table leaf_table_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .leaf_wen    (leaf_wen),
    .rd_en       (receiver_en),
    .leaf_addr   (leaf_addr),
    .leaf_data   (leaf_data),
    .rd_index    (leaf_index),
    .match_valid (match_valid),
    .match_leaf  (match_leaf),
    .match_id    (match_id)
  );

endmodule

// File: hdl/leaf_table.sv
`timescale 1ns/1ps

module leaf_table (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     leaf_wen,      // Host write
  input  logic                     rd_en,         // Leaf index from the tree is valid
  input  kd_tree_pkg::leaf_index_t leaf_addr,
  input  patch_pkg::match_id_t     leaf_data,
  input  kd_tree_pkg::leaf_index_t rd_index,
  output logic                     match_valid,
  output kd_tree_pkg::leaf_index_t match_leaf,
  output patch_pkg::match_id_t     match_id
);

  patch_pkg::match_id_t id_mem [kd_tree_pkg::NUM_LEAVES];   // One id per leaf

  // Host writes, visible to reads on the next cycle
  always_ff @(posedge clk) begin
    if (leaf_wen) begin
      id_mem[leaf_addr] <= leaf_data;
    end
  end

  // Registered lookup
  always_ff @(posedge clk) begin
    if (rd_en) begin
      match_id   <= id_mem[rd_index];
      match_leaf <= rd_index;   // Leaf travels with its id
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= rd_en;
    end
  end

endmodule

// File: hdl/tree_ctrl.sv
`timescale 1ns/1ps

module tree_ctrl (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       load_start,    // Host pulse that begins a tree load
  input  logic       tree_full,     // All nodes written
  input  logic       patch_valid,
  output logic       load_enable,   // Load mode level
  output logic       tree_ready,
  output logic       patch_en,      // Patch forwarded into the tree
  output logic [7:0] drop_count     // Saturating count of refused patches
);

  logic patch_drop;

  // Load mode is set on start and cleared once the tree fills
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_enable <= 1'b0;
    end else if (load_start) begin
      load_enable <= 1'b1;   // Start wins over a full tree on reload
    end else if (tree_full) begin
      load_enable <= 1'b0;
    end
  end

  assign tree_ready = !load_enable && tree_full;

  // Gate incoming patches
  assign patch_en   = patch_valid && tree_ready;
  assign patch_drop = patch_valid && !tree_ready;

  // Drop counter holds at 255
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (patch_drop && (drop_count != 8'hff)) begin
      drop_count <= drop_count + 8'd1;
    end
  end

  a_no_ready_in_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_enable && tree_ready))
    else $error("tree_ready raised while still loading");

endmodule

// File: hdl/internal_node_tree.sv
`timescale 1ns/1ps

module internal_node_tree (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fsm_enable,      // Load mode from the control block
  input  logic                     sender_enable,   // Node write strobe
  input  logic                     load_restart,    // Back to node 0
  input  logic                     patch_en,
  input  kd_tree_pkg::node_word_t  sender_data,
  input  patch_pkg::patch_t        patch_in,
  output kd_tree_pkg::leaf_index_t leaf_index,
  output logic                     receiver_en,
  output logic                     tree_full
);

  logic [kd_tree_pkg::NODE_ADDR_WIDTH-1:0] wadr;   // Next node to write in breadth-first order
  logic                                    write_accept;
  logic [kd_tree_pkg::NUM_NODES-1:0]       node_wen;

  // Patch copy per level (level 0 reads patch_in directly)
  patch_pkg::patch_t patch_q [1:kd_tree_pkg::TREE_DEPTH-1];

  // Heap numbering where node n feeds 2n+1 (left) and 2n+2 (right)
  // Entries 1..62 are inner nodes and 63..126 are the leaves
  logic [2*kd_tree_pkg::NUM_LEAVES-2:1] child_valid;
  logic [2*kd_tree_pkg::NUM_LEAVES-2:1] valid_q;
  logic [kd_tree_pkg::NUM_LEAVES-1:0]   leaf_valid;

  logic [kd_tree_pkg::TREE_DEPTH-1:0] en_pipe;   // Tracks the patch down the levels

  // Writes stop once all nodes are filled
  assign write_accept = fsm_enable && sender_enable && !tree_full;

  // Address counter and full flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wadr      <= '0;
      tree_full <= 1'b0;
    end else if (load_restart) begin
      wadr      <= '0;
      tree_full <= 1'b0;   // Tree goes stale until reloaded
    end else if (write_accept) begin
      wadr <= wadr + 1'b1;
      if (int'(wadr) == kd_tree_pkg::NUM_NODES - 1) begin
        tree_full <= 1'b1;   // Last node just written
      end
    end
  end

  // One-hot write decoder
  always_comb begin
    for (int n = 0; n < kd_tree_pkg::NUM_NODES; n++) begin
      node_wen[n] = write_accept && (int'(wadr) == n);
    end
  end

  // Patch payload moves one level per cycle
  always_ff @(posedge clk) begin
    patch_q[1] <= patch_in;
    for (int l = 2; l < kd_tree_pkg::TREE_DEPTH; l++) begin
      patch_q[l] <= patch_q[l-1];
    end
  end

  // Valid bits of every level registered together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= child_valid;
    end
  end

  // Six stages that line up with the last valid level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_pipe <= '0;
    end else begin
      en_pipe <= {en_pipe[kd_tree_pkg::TREE_DEPTH-2:0], patch_en};
    end
  end

  assign receiver_en = en_pipe[kd_tree_pkg::TREE_DEPTH-1];

  // Node array
  for (genvar lvl = 0; lvl < kd_tree_pkg::TREE_DEPTH; lvl++) begin : g_level
    patch_pkg::patch_t lvl_patch;   // Patch seen by every node of this level

    if (lvl == 0) begin : g_root_patch
      assign lvl_patch = patch_in;
    end else begin : g_pipe_patch
      assign lvl_patch = patch_q[lvl];
    end

    for (genvar pos = 0; pos < 2**lvl; pos++) begin : g_node
      localparam int NODE = 2**lvl + pos - 1;   // Matches the write address
      logic node_valid;

      if (NODE == 0) begin : g_root_valid
        assign node_valid = patch_en;   // Root sees the new patch straight away
      end else begin : g_inner_valid
        assign node_valid = valid_q[NODE];
      end

      internal_node node_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wen         (node_wen[NODE]),
        .valid       (node_valid),
        .wdata       (sender_data),
        .patch_in    (lvl_patch),
        .valid_left  (child_valid[2*NODE+1]),
        .valid_right (child_valid[2*NODE+2])
      );
    end
  end

  // Last level from left to right
  assign leaf_valid = valid_q[2*kd_tree_pkg::NUM_LEAVES-2:kd_tree_pkg::NUM_LEAVES-1];

  // Encoder for the single set bit
  always_comb begin
    leaf_index = '0;
    for (int k = 0; k < kd_tree_pkg::NUM_LEAVES; k++) begin
      if (leaf_valid[k]) begin
        leaf_index = kd_tree_pkg::leaf_index_t'(k);
      end
    end
  end

  // Shift register and node datapath must agree on where the patch is
  a_leaf_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    receiver_en |-> $onehot(leaf_valid))
    else $error("Leaf level not one-hot while receiver_en is set");

  a_leaf_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !receiver_en |-> (leaf_valid == '0))
    else $error("Stray valid bit in leaf level");

endmodule

// File: hdl/internal_node.sv
`timescale 1ns/1ps

module internal_node (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wen,          // Host write to this node
  input  logic                    valid,        // Patch at this level routed here
  input  kd_tree_pkg::node_word_t wdata,
  input  patch_pkg::patch_t       patch_in,
  output logic                    valid_left,
  output logic                    valid_right
);

  kd_tree_pkg::node_word_t node_q;      // Split axis and threshold
  patch_pkg::component_t   component;   // Component picked by the axis
  logic                    go_right;

  // Node word, loaded once per tree load
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_q <= '0;
    end else if (wen) begin
      node_q <= wdata;
    end
  end

  // Axis mux, anything past the last component falls back to component 4
  always_comb begin
    component = patch_in[(patch_pkg::NUM_COMPONENTS-1)*patch_pkg::COMPONENT_WIDTH +:
                         patch_pkg::COMPONENT_WIDTH];
    for (int c = 0; c < patch_pkg::NUM_COMPONENTS - 1; c++) begin
      if (int'(node_q.axis) == c) begin
        component = patch_in[c*patch_pkg::COMPONENT_WIDTH +: patch_pkg::COMPONENT_WIDTH];
      end
    end
  end

  assign go_right = (component >= node_q.thresh);   // Ties go right

  // Only one child sees the valid bit
  assign valid_right = valid && go_right;
  assign valid_left  = valid && !go_right;

endmodule

// File: hdl/patch_pkg.sv
package patch_pkg;

  // Patch layout, component 0 in the low bits
  localparam int NUM_COMPONENTS  = 5;
  localparam int COMPONENT_WIDTH = 11;
  localparam int PATCH_WIDTH     = NUM_COMPONENTS * COMPONENT_WIDTH;   // 55 bits

  typedef logic [PATCH_WIDTH-1:0]     patch_t;
  typedef logic [COMPONENT_WIDTH-1:0] component_t;

  // Candidate id stored per leaf
  localparam int MATCH_ID_WIDTH = 8;

  typedef logic [MATCH_ID_WIDTH-1:0] match_id_t;

endpackage

// File: hdl/kd_tree_pkg.sv
package kd_tree_pkg;

  // Tree shape, six levels of split nodes above the leaves
  localparam int TREE_DEPTH = 6;
  localparam int NUM_NODES  = 2**TREE_DEPTH - 1;   // 63 internal nodes
  localparam int NUM_LEAVES = 2**TREE_DEPTH;       // 64 leaves

  // Breadth-first node address, node at level i position j sits at 2^i + j - 1
  localparam int NODE_ADDR_WIDTH = 6;

  // Node word fields
  localparam int AXIS_WIDTH   = 3;    // Enough for 5 components
  localparam int THRESH_WIDTH = 11;   // Same width as one patch component
  localparam int NODE_WIDTH   = AXIS_WIDTH + THRESH_WIDTH;

  // Axis in the top bits, threshold below
  typedef struct packed {
    logic [AXIS_WIDTH-1:0]   axis;     // Component to split on, 5 and up clamp to 4
    logic [THRESH_WIDTH-1:0] thresh;   // Go right when component >= thresh
  } node_word_t;

  // Leaf number, first-level decision in the MSB
  typedef logic [TREE_DEPTH-1:0] leaf_index_t;

endpackage
